// File: pio_bus_pkg.sv
`default_nettype none

`include "pio_settings.svh"

package pio_bus_pkg;

  typedef logic [31:0]                             word_t;
  typedef logic [`PIO_WB_ADDR_W-1:0]               wb_addr_t;
  typedef logic [$clog2(`PIO_NUM_MACHINES)-1:0]    mindex_t;

  // Commands from the bus side into the core
  typedef enum logic [2:0] {
    ACT_NONE,
    ACT_INSTR,
    ACT_WRAP,
    ACT_PULL,
    ACT_PUSH,
    ACT_GRPS,
    ACT_EN
  } action_e;

  // Word addresses
  localparam wb_addr_t REG_IMEM_TOP  = 'h1F;
  localparam wb_addr_t REG_CTRL      = 'h20;
  localparam wb_addr_t REG_FSTAT     = 'h21;
  localparam wb_addr_t REG_MACH_BASE = 'h24;   // Four words per machine

  // Offsets inside a machine block
  localparam logic [1:0] OFS_TXF     = 2'd0;
  localparam logic [1:0] OFS_RXF     = 2'd1;
  localparam logic [1:0] OFS_PINCTRL = 2'd2;
  localparam logic [1:0] OFS_WRAP    = 2'd3;

endpackage

`default_nettype wire

// File: pio_chk.sv
`default_nettype none
`timescale 1ns/100ps

`include "pio_settings.svh"

module pio_chk (
  input wire                         clk,
  input wire                         reset,
  input wire                         wb_stb,
  input wire                         wb_ack,
  input wire [`PIO_NUM_MACHINES-1:0] tx_push,
  input wire [`PIO_NUM_MACHINES-1:0] tx_full,
  input wire [`PIO_NUM_MACHINES-1:0] rx_pull,
  input wire [`PIO_NUM_MACHINES-1:0] rx_empty
);

  ack_needs_stb: assert property (@(posedge clk) disable iff (reset) wb_ack |-> wb_stb)
    else $error("wb_ack without wb_stb");

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one cycle");

  // Host side of the TX and RX FIFOs
  fifo_overflow: assert property (@(posedge clk) disable iff (reset)
    (tx_push & tx_full) == '0)
    else $error("TX FIFO pushed while full");

  fifo_underflow: assert property (@(posedge clk) disable iff (reset)
    (rx_pull & rx_empty) == '0)
    else $error("RX FIFO pulled while empty");

endmodule

bind pio_top pio_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .tx_push  (u_core.tx_push),
  .tx_full  (u_core.tx_full),
  .rx_pull  (u_core.rx_pull),
  .rx_empty (u_core.rx_empty)
);

`default_nettype wire

// File: pio_core.sv
`default_nettype none
`timescale 1ns/100ps

`include "pio_settings.svh"

module pio_core (
  input  wire                          clk,
  input  wire                          reset,
  input  wire pio_bus_pkg::action_e    action,
  input  wire pio_bus_pkg::mindex_t    mindex,
  input  wire pio_isa_pkg::imem_addr_t index,
  input  wire pio_bus_pkg::word_t      din,
  input  wire pio_bus_pkg::word_t      gpio_in,
  output pio_bus_pkg::word_t           gpio_out,
  output pio_bus_pkg::word_t           gpio_dir,
  output pio_bus_pkg::word_t           dout,
  output logic [`PIO_NUM_MACHINES-1:0] tx_full,
  output logic [`PIO_NUM_MACHINES-1:0] rx_empty
);
  import pio_isa_pkg::*;
  import pio_bus_pkg::*;

  localparam int N = `PIO_NUM_MACHINES;

  instr_t     imem       [`PIO_IMEM_DEPTH];   // Shared program store
  instr_t     curr_instr [N];
  word_t      tx_wdata;

  logic [N-1:0] en;
  logic [N-1:0] restart;
  logic [N-1:0] tx_push;
  logic [N-1:0] rx_pull;

  imem_addr_t wrap_target [N];
  imem_addr_t wrap_top    [N];
  pin_idx_t   out_base    [N];
  pin_cnt_t   out_count   [N];
  pin_idx_t   set_base    [N];
  logic [2:0] set_count   [N];
  pin_idx_t   in_base     [N];

  imem_addr_t   pc        [N];
  word_t        mach_pins [N];
  word_t        tx_dout   [N];
  word_t        rx_din    [N];
  word_t        rx_dout   [N];
  logic [N-1:0] tx_empty;
  logic [N-1:0] rx_full;
  logic [N-1:0] m_pull;
  logic [N-1:0] m_push;
  word_t        grp;

  always_ff @(posedge clk) begin
    if (action == ACT_INSTR)
      imem[index] <= din[15:0];
    if (action == ACT_PUSH)
      tx_wdata <= din;   // Pushed with the strobe a cycle later
    if (action == ACT_PULL)
      dout <= rx_dout[mindex];
    for (int m = 0; m < N; m++)
      curr_instr[m] <= imem[pc[m]];   // One read port per machine
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en      <= '0;
      restart <= '0;
      tx_push <= '0;
      rx_pull <= '0;
      for (int m = 0; m < N; m++) begin
        wrap_target[m] <= '0;
        wrap_top[m]    <= '0;
        out_base[m]    <= '0;
        out_count[m]   <= '0;
        set_base[m]    <= '0;
        set_count[m]   <= 3'd5;
        in_base[m]     <= '0;
      end
    end else begin
      restart <= '0;
      tx_push <= '0;
      rx_pull <= '0;
      case (action)
        ACT_EN: begin
          en      <= din[N-1:0];
          restart <= din[4 +: N];
        end
        ACT_PUSH: tx_push[mindex] <= 1'b1;
        ACT_PULL: rx_pull[mindex] <= 1'b1;
        ACT_GRPS: begin
          out_base[mindex]  <= din[4:0];
          out_count[mindex] <= din[10:5];
          set_base[mindex]  <= din[15:11];
          set_count[mindex] <= din[18:16];
          in_base[mindex]   <= din[23:19];
        end
        ACT_WRAP: begin
          wrap_target[mindex] <= din[4:0];
          wrap_top[mindex]    <= din[9:5];
        end
        default: ;
      endcase
    end
  end

  // Later machines override earlier ones on shared pins
  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    grp      = '0;
    for (int m = 0; m < N; m++) begin
      grp = rotl(low_mask(out_count[m]), out_base[m])
          | rotl(low_mask(pin_cnt_t'(set_count[m])), set_base[m]);
      if (en[m]) begin
        gpio_out = (gpio_out & ~grp) | (mach_pins[m] & grp);
        gpio_dir = gpio_dir | grp;
      end
    end
  end

  for (genvar m = 0; m < N; m++) begin : g_mach
    pio_machine u_machine (
      .clk         (clk),
      .reset       (reset),
      .en          (en[m]),
      .restart     (restart[m]),
      .instr       (curr_instr[m]),
      .wrap_target (wrap_target[m]),
      .wrap_top    (wrap_top[m]),
      .out_base    (out_base[m]),
      .out_count   (out_count[m]),
      .set_base    (set_base[m]),
      .set_count   (set_count[m]),
      .in_base     (in_base[m]),
      .input_pins  (gpio_in),
      .fifo_din    (tx_dout[m]),
      .fifo_empty  (tx_empty[m]),
      .fifo_full   (rx_full[m]),
      .pc          (pc[m]),
      .output_pins (mach_pins[m]),
      .fifo_pull   (m_pull[m]),
      .fifo_push   (m_push[m]),
      .fifo_dout   (rx_din[m])
    );

    pio_fifo u_tx_fifo (   // Host to machine
      .clk   (clk),
      .reset (reset),
      .push  (tx_push[m]),
      .pull  (m_pull[m]),
      .din   (tx_wdata),
      .dout  (tx_dout[m]),
      .full  (tx_full[m]),
      .empty (tx_empty[m])
    );

    pio_fifo u_rx_fifo (   // Machine to host
      .clk   (clk),
      .reset (reset),
      .push  (m_push[m]),
      .pull  (rx_pull[m]),
      .din   (rx_din[m]),
      .dout  (rx_dout[m]),
      .full  (rx_full[m]),
      .empty (rx_empty[m])
    );
  end

endmodule

`default_nettype wire

// File: pio_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "pio_settings.svh"

module pio_fifo (
  input  wire                clk,
  input  wire                reset,
  input  wire                push,
  input  wire                pull,
  input  wire pio_bus_pkg::word_t din,
  output pio_bus_pkg::word_t dout,
  output logic               full,
  output logic               empty
);
  import pio_bus_pkg::*;

  localparam int DEPTH = `PIO_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;

  assign dout  = mem[rd_ptr];   // Head word, visible before the pull
  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pull)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pull)
        count <= count + 1'b1;
      else if (pull && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

endmodule

`default_nettype wire

// File: pio_isa_pkg.sv
`default_nettype none

package pio_isa_pkg;

  typedef logic [15:0] instr_t;
  typedef logic [4:0]  imem_addr_t;
  typedef logic [4:0]  pin_idx_t;
  typedef logic [5:0]  pin_cnt_t;   // Up to 32 pins

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,   // Bit 7 selects PULL
    OP_SET      = 3'd7
  } opcode_e;

  typedef enum logic [2:0] {
    COND_ALWAYS = 3'd0,
    COND_XZERO  = 3'd1,
    COND_XDEC   = 3'd2,
    COND_OSRE   = 3'd7
  } jmp_cond_e;

  typedef enum logic [2:0] {
    OPND_PINS = 3'd0,
    OPND_X    = 3'd1,
    OPND_NULL = 3'd3
  } operand_e;

  // Ones in the n lowest bits, all ones from 32 up
  function automatic logic [31:0] low_mask(pin_cnt_t n);
    logic [63:0] m;
    m = (64'd1 << n) - 64'd1;
    return m[31:0];
  endfunction

  function automatic logic [31:0] rotl(logic [31:0] v, pin_idx_t n);
    logic [63:0] d;
    d = {v, v} << n;
    return d[63:32];
  endfunction

  function automatic logic [31:0] rotr(logic [31:0] v, pin_idx_t n);
    logic [63:0] d;
    d = {v, v} >> n;
    return d[31:0];
  endfunction

endpackage

`default_nettype wire

// File: pio_machine.sv
`default_nettype none
`timescale 1ns/100ps

module pio_machine (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          en,
  input  wire                          restart,
  input  wire pio_isa_pkg::instr_t     instr,
  input  wire pio_isa_pkg::imem_addr_t wrap_target,
  input  wire pio_isa_pkg::imem_addr_t wrap_top,
  input  wire pio_isa_pkg::pin_idx_t   out_base,
  input  wire pio_isa_pkg::pin_cnt_t   out_count,
  input  wire pio_isa_pkg::pin_idx_t   set_base,
  input  wire [2:0]                    set_count,
  input  wire pio_isa_pkg::pin_idx_t   in_base,
  input  wire pio_bus_pkg::word_t      input_pins,
  input  wire pio_bus_pkg::word_t      fifo_din,
  input  wire                          fifo_empty,
  input  wire                          fifo_full,
  output pio_isa_pkg::imem_addr_t      pc,
  output pio_bus_pkg::word_t           output_pins,
  output logic                         fifo_pull,
  output logic                         fifo_push,
  output pio_bus_pkg::word_t           fifo_dout
);
  import pio_isa_pkg::*;
  import pio_bus_pkg::*;

  typedef enum logic [1:0] {PH_FETCH, PH_EXEC, PH_STALL} phase_e;

  phase_e     phase;
  word_t      x;
  word_t      osr;
  word_t      isr;
  pin_cnt_t   osr_cnt;    // Bits shifted out since the last PULL
  logic [6:0] osr_sum;
  opcode_e    op;
  jmp_cond_e  cond;
  operand_e   opnd;
  pin_cnt_t   cnt;
  logic       exec;
  logic       is_pull;
  logic       blocked;
  logic       take;
  word_t      out_data;
  word_t      in_data;
  word_t      out_mask;
  word_t      set_mask;
  imem_addr_t next_pc;

  assign op      = opcode_e'(instr[15:13]);
  assign cond    = jmp_cond_e'(instr[7:5]);
  assign opnd    = operand_e'(instr[7:5]);
  assign cnt     = (instr[4:0] == 5'd0) ? 6'd32 : {1'b0, instr[4:0]};
  assign is_pull = instr[7];
  assign exec    = en && !restart && (phase != PH_FETCH);
  assign blocked = (op == OP_PUSHPULL) && (is_pull ? fifo_empty : fifo_full);

  assign fifo_pull = exec && (op == OP_PUSHPULL) && is_pull && !fifo_empty;
  assign fifo_push = exec && (op == OP_PUSHPULL) && !is_pull && !fifo_full;
  assign fifo_dout = isr;

  assign out_data = osr & low_mask(cnt);   // OUT takes the low bits
  assign osr_sum  = {1'b0, osr_cnt} + {1'b0, cnt};
  assign out_mask = rotl(low_mask(out_count), out_base);
  assign set_mask = rotl(low_mask(pin_cnt_t'(set_count)), set_base);

  always_comb begin
    case (opnd)
      OPND_PINS: in_data = rotr(input_pins, in_base);
      OPND_X:    in_data = x;
      default:   in_data = '0;
    endcase
    case (cond)
      COND_ALWAYS: take = 1'b1;
      COND_XZERO:  take = (x == '0);
      COND_XDEC:   take = (x != '0);   // Tested before the decrement
      COND_OSRE:   take = (osr_cnt == 6'd32);
      default:     take = 1'b0;
    endcase
    if (op == OP_JMP && take)
      next_pc = instr[4:0];
    else if (pc == wrap_top)
      next_pc = wrap_target;
    else
      next_pc = pc + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      phase   <= PH_FETCH;
      pc      <= '0;
      x       <= '0;
      osr     <= '0;
      isr     <= '0;
      osr_cnt <= 6'd32;
    end else if (en) begin
      if (phase == PH_FETCH) begin
        phase <= PH_EXEC;
      end else if (blocked) begin
        phase <= PH_STALL;   // Retry next cycle, pc held
      end else begin
        phase <= PH_FETCH;
        pc    <= next_pc;
        case (op)
          OP_JMP: begin
            if (cond == COND_XDEC)
              x <= x - 1'b1;
          end
          OP_IN: isr <= (isr << cnt) | (in_data & low_mask(cnt));
          OP_OUT: begin
            osr     <= osr >> cnt;
            osr_cnt <= (osr_sum > 7'd32) ? 6'd32 : osr_sum[5:0];
            if (opnd == OPND_X)
              x <= out_data;
          end
          OP_SET: begin
            if (opnd == OPND_X)
              x <= word_t'(instr[4:0]);
          end
          OP_PUSHPULL: begin
            if (is_pull) begin
              osr     <= fifo_din;
              osr_cnt <= '0;
            end else begin
              isr <= '0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Pin drivers survive a restart
  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins <= '0;
    end else if (exec && !blocked) begin
      if (op == OP_OUT && opnd == OPND_PINS)
        output_pins <= (output_pins & ~out_mask) | (rotl(out_data, out_base) & out_mask);
      else if (op == OP_SET && opnd == OPND_PINS)
        output_pins <= (output_pins & ~set_mask) | (rotl(word_t'(instr[4:0]), set_base) & set_mask);
    end
  end

endmodule

`default_nettype wire

// File: pio_settings.svh
`ifndef PIO_SETTINGS_SVH
`define PIO_SETTINGS_SVH

// State machines sharing one instruction memory
`define PIO_NUM_MACHINES 2

// Words per TX or RX FIFO
`define PIO_FIFO_DEPTH 4

`define PIO_IMEM_DEPTH 32

// Word address bits on the Wishbone side
`define PIO_WB_ADDR_W 6

`endif

// File: pio_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "pio_settings.svh"

module pio_top (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        wb_cyc,
  input  wire                        wb_stb,
  input  wire                        wb_we,
  input  wire pio_bus_pkg::wb_addr_t wb_adr,
  input  wire pio_bus_pkg::word_t    wb_dat_w,
  output pio_bus_pkg::word_t         wb_dat_r,
  output logic                       wb_ack,
  input  wire pio_bus_pkg::word_t    gpio_in,
  output pio_bus_pkg::word_t         gpio_out,
  output pio_bus_pkg::word_t         gpio_dir
);
  import pio_isa_pkg::*;
  import pio_bus_pkg::*;

  // Core command, one cycle per bus access
  action_e    action;
  mindex_t    mindex;
  imem_addr_t index;
  word_t      din;
  word_t      core_dout;

  logic [`PIO_NUM_MACHINES-1:0] tx_full;
  logic [`PIO_NUM_MACHINES-1:0] rx_empty;

  pio_wb_regs u_wb_regs (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .core_dout (core_dout),
    .tx_full   (tx_full),
    .rx_empty  (rx_empty),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .action    (action),
    .mindex    (mindex),
    .index     (index),
    .din       (din)
  );

  pio_core u_core (
    .clk      (clk),
    .reset    (reset),
    .action   (action),
    .mindex   (mindex),
    .index    (index),
    .din      (din),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .dout     (core_dout),
    .tx_full  (tx_full),
    .rx_empty (rx_empty)
  );

endmodule

`default_nettype wire

// File: pio_wb_regs.sv
`default_nettype none
`timescale 1ns/100ps

`include "pio_settings.svh"

module pio_wb_regs (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          wb_cyc,
  input  wire                          wb_stb,
  input  wire                          wb_we,
  input  wire pio_bus_pkg::wb_addr_t   wb_adr,
  input  wire pio_bus_pkg::word_t      wb_dat_w,
  input  wire pio_bus_pkg::word_t      core_dout,
  input  wire [`PIO_NUM_MACHINES-1:0]  tx_full,
  input  wire [`PIO_NUM_MACHINES-1:0]  rx_empty,
  output pio_bus_pkg::word_t           wb_dat_r,
  output logic                         wb_ack,
  output pio_bus_pkg::action_e         action,
  output pio_bus_pkg::mindex_t         mindex,
  output pio_isa_pkg::imem_addr_t      index,
  output pio_bus_pkg::word_t           din
);
  import pio_bus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_FIFO, ST_READ_DATA, ST_ACK} state_e;

  state_e     state;
  wb_addr_t   mach_off;
  logic [1:0] ofs;
  logic       in_mach;
  logic       is_txf;
  logic       is_rxf;
  logic       blocked;
  logic       req;
  logic       go;
  word_t      fstat;

  assign mach_off = wb_adr - REG_MACH_BASE;
  assign ofs      = mach_off[1:0];
  assign in_mach  = (wb_adr >= REG_MACH_BASE)
                 && (mach_off < wb_addr_t'(4 * `PIO_NUM_MACHINES));
  assign mindex   = mindex_t'(mach_off >> 2);
  assign index    = wb_adr[4:0];
  assign din      = wb_dat_w;

  assign is_txf  = in_mach && wb_we && (ofs == OFS_TXF);
  assign is_rxf  = in_mach && !wb_we && (ofs == OFS_RXF);
  assign blocked = (is_txf && tx_full[mindex]) || (is_rxf && rx_empty[mindex]);
  assign req     = wb_cyc && wb_stb && (state == ST_IDLE || state == ST_WAIT_FIFO);
  assign go      = req && !blocked;   // The one cycle that carries the action
  assign wb_ack  = (state == ST_ACK);
  assign fstat   = (word_t'(rx_empty) << 8) | word_t'(tx_full);

  always_comb begin
    action = ACT_NONE;
    if (go) begin
      if (wb_we && wb_adr <= REG_IMEM_TOP)
        action = ACT_INSTR;
      else if (wb_we && wb_adr == REG_CTRL)
        action = ACT_EN;
      else if (is_txf)
        action = ACT_PUSH;
      else if (is_rxf)
        action = ACT_PULL;
      else if (wb_we && in_mach && ofs == OFS_PINCTRL)
        action = ACT_GRPS;
      else if (wb_we && in_mach && ofs == OFS_WRAP)
        action = ACT_WRAP;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_WAIT_FIFO: begin
          if (req && blocked)
            state <= ST_WAIT_FIFO;
          else if (req && is_rxf)
            state <= ST_READ_DATA;   // Core registers dout first
          else if (req)
            state <= ST_ACK;
          else
            state <= ST_IDLE;        // Also drops an abandoned cycle
        end
        ST_READ_DATA: state <= ST_ACK;
        default:      state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_READ_DATA)
      wb_dat_r <= core_dout;
    else if (go)
      wb_dat_r <= (wb_adr == REG_FSTAT) ? fstat : '0;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pio -f sources.f -o sim_pio

# The simulator exits non-zero on failure; the log decides the result
./obj_dir/sim_pio > sim.log 2>&1 || true
cat sim.log

grep -q "TESTS PASSED" sim.log

// File: sources.f
+incdir+.
pio_isa_pkg.sv
pio_bus_pkg.sv
pio_fifo.sv
pio_machine.sv
pio_core.sv
pio_wb_regs.sv
pio_top.sv
tb_clkgen.sv
pio_chk.sv
tb_pio.sv

// File: tb_clkgen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

  always #50 clk = ~clk;   // 100 ns period

endmodule

`default_nettype wire

// File: tb_pio.sv
`default_nettype none
`timescale 1ns/100ps

module tb_pio;
  import pio_bus_pkg::*;

  localparam int NUM_ROWS   = 8;
  localparam int MAX_CYCLES = 40 * NUM_ROWS + 2000;

  logic     clk;
  logic     reset;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  word_t    wb_dat_w;
  word_t    wb_dat_r;
  logic     wb_ack;
  word_t    gpio_in = '0;
  word_t    gpio_out;
  word_t    gpio_dir;

  word_t    pin_drive = '0;
  logic     loopback = 1'b0;   // Feed gpio_out back into gpio_in
  int       cycles = 0;

  // Programs back to back for pass-through, countdown, overlap and restart
  logic [15:0] program_table [0:16] = '{
    16'h8080, 16'h6008, 16'h4008, 16'h8000, 16'h0000,
    16'hE023, 16'h4020, 16'h8000, 16'h0041,
    16'h8080, 16'h6000, 16'h0000,
    16'hE001, 16'h8080, 16'hE002, 16'h8080, 16'h0000
  };

  // Stimulus and expected values for each pass-through step
  word_t row_tx      [NUM_ROWS];
  word_t row_in      [NUM_ROWS];
  word_t row_exp_out [NUM_ROWS];
  word_t row_exp_rx  [NUM_ROWS];

  tb_clkgen u_clkgen (
    .clk   (clk),
    .reset (reset)
  );

  pio_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir)
  );

  always @(posedge clk)
    gpio_in <= loopback ? gpio_out : pin_drive;

  task automatic stop_failed();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      stop_failed();
    end
  end

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL time %0t %s got %08h expected %08h", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic start_cycle(input logic we, input wb_addr_t adr, input word_t wdata);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
  endtask

  task automatic end_cycle();
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_access(input logic we, input wb_addr_t adr, input word_t wdata,
                            output word_t rdata);
    start_cycle(we, adr, wdata);
    @(negedge clk);
    while (!wb_ack)
      @(negedge clk);
    rdata = wb_dat_r;
    end_cycle();
  endtask

  task automatic write_reg(input wb_addr_t adr, input word_t data);
    word_t unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input wb_addr_t adr, output word_t data);
    bus_access(1'b0, adr, '0, data);
  endtask

  // Holds a blocked access for 20 cycles and then abandons it
  task automatic expect_no_ack(input logic we, input wb_addr_t adr, input word_t wdata);
    start_cycle(we, adr, wdata);
    repeat (20) begin
      @(negedge clk);
      if (wb_ack) begin
        $display("Bus access to register %02h completed while its FIFO was blocked", adr);
        stop_failed();
      end
    end
    end_cycle();
  endtask

  task automatic load_program(input int first, input int len);
    for (int i = 0; i < len; i++)
      write_reg(wb_addr_t'(i), word_t'(program_table[first + i]));
  endtask

  task automatic set_pins(input word_t value);
    @(posedge clk);
    pin_drive <= value;
  endtask

  // Pins settle some cycles after the FIFO write
  task automatic wait_pins(input word_t mask, input word_t exp, input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (((gpio_out & mask) != exp) && n < 40) begin
      @(negedge clk);
      n++;
    end
    check(name, gpio_out & mask, exp);
  endtask

  initial begin
    word_t rd;
    word_t w0;
    word_t w1;
    word_t exp;
    word_t mask0;
    word_t mask1;
    word_t bp_words [5];

    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    void'($urandom(68673));

    for (int i = 0; i < NUM_ROWS; i++) begin
      row_tx[i]      = $urandom();
      row_in[i]      = $urandom();
      row_exp_out[i] = {24'h0, row_tx[i][7:0]};    // OUT 8 to pins 15:8
      row_exp_rx[i]  = {24'h0, row_in[i][23:16]};  // IN 8 from base 16
    end

    wait (reset === 1'b0);
    @(negedge clk);

    // After reset
    check("gpio_out", gpio_out, '0);
    check("gpio_dir", gpio_dir, '0);
    read_reg(6'h21, rd);
    check("fstat", rd, 32'h0000_0300);
    expect_no_ack(1'b0, 6'h25, '0);

    // Pass-through on machine 0
    load_program(0, 5);
    write_reg(6'h27, 32'h0000_0080);
    write_reg(6'h26, 32'h0080_0108);
    write_reg(6'h20, 32'h0000_0011);
    for (int i = 0; i < NUM_ROWS; i++) begin
      set_pins(row_in[i]);
      write_reg(6'h24, row_tx[i]);
      read_reg(6'h25, rd);
      check("rx word m0", rd, row_exp_rx[i]);
      @(negedge clk);
      check("gpio_out[15:8]", (gpio_out >> 8) & 32'hFF, row_exp_out[i]);
    end
    check("gpio_dir", gpio_dir, 32'h0000_FF00);

    // Countdown on machine 1 and a wrap back to SET
    write_reg(6'h20, '0);
    load_program(5, 4);
    write_reg(6'h2B, 32'h0000_0060);
    write_reg(6'h20, 32'h0000_0022);
    for (int k = 0; k < 5; k++) begin
      read_reg(6'h29, rd);
      exp = (k < 4) ? word_t'(3 - k) : 32'd3;
      check("rx word m1", rd, exp);
    end

    // Overlapping out groups with machine 1 on top
    write_reg(6'h20, '0);
    load_program(9, 3);
    write_reg(6'h26, 32'h0000_0200);
    write_reg(6'h2A, 32'h0000_0208);
    write_reg(6'h20, 32'h0000_0033);
    w0 = $urandom();
    w1 = $urandom();
    write_reg(6'h24, w0);
    write_reg(6'h28, w1);
    mask0 = 32'h0000_FFFF;
    mask1 = 32'h00FF_FF00;
    exp   = (w0 & mask0 & ~mask1) | ((w1 << 8) & mask1);
    wait_pins(32'hFFFF_FFFF, exp, "gpio_out overlap");
    check("gpio_dir", gpio_dir, mask0 | mask1);

    // Back-pressure with pins looped back and in base 8
    write_reg(6'h20, '0);
    load_program(0, 5);
    write_reg(6'h26, 32'h0040_0108);
    @(posedge clk);
    loopback <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      bp_words[i] = $urandom();
      write_reg(6'h24, bp_words[i]);
    end
    read_reg(6'h21, rd);
    check("fstat tx_full", rd & 32'h3, 32'h1);
    check("fstat rx_empty m0", (rd >> 8) & 32'h1, 32'h1);
    bp_words[4] = $urandom();
    expect_no_ack(1'b1, 6'h24, bp_words[4]);
    write_reg(6'h20, 32'h0000_0011);
    write_reg(6'h24, bp_words[4]);
    for (int i = 0; i < 5; i++) begin
      read_reg(6'h25, rd);
      check("rx word back-pressure", rd, {24'h0, bp_words[i][7:0]});
    end
    @(posedge clk);
    loopback <= 1'b0;

    // Restart sends the pc back to the first SET
    write_reg(6'h20, '0);
    load_program(12, 5);
    write_reg(6'h26, 32'h0002_0000);
    write_reg(6'h20, 32'h0000_0011);
    wait_pins(32'h3, 32'h1, "gpio_out[1:0] first SET");
    write_reg(6'h24, $urandom());
    wait_pins(32'h3, 32'h2, "gpio_out[1:0] second SET");
    write_reg(6'h20, 32'h0000_0011);
    wait_pins(32'h3, 32'h1, "gpio_out[1:0] after restart");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
